// ==== hw/memAccessPkg.sv ====
package memAccessPkg;

    localparam int DATA_WIDTH     = 32;                    // data word width
    localparam int ADDR_WIDTH     = 32;                    // byte address width
    localparam int RAM_WORDS_LOG2 = 8;                     // 256 words, 1 KiB
    localparam int RAM_WORDS      = 1 << RAM_WORDS_LOG2;
    localparam int BYTE_LANES     = DATA_WIDTH / 8;        // one write enable per byte

    typedef enum logic [3:0] {
        NOP = 4'd0,
        LB,                                                // signed byte
        LBU,                                               // unsigned byte
        LH,
        LHU,
        LW,
        LWL,                                               // left partial word
        LWR,                                               // right partial word
        SB,
        SH,
        SW,
        SWL,
        SWR
    } memOp;

    function automatic logic isStoreOp(input memOp op);
        case (op)
            SB, SH, SW, SWL, SWR: return 1'b1;
            default:              return 1'b0;
        endcase
    endfunction

    function automatic logic isLoadOp(input memOp op);
        case (op)
            LB, LBU, LH, LHU, LW, LWL, LWR: return 1'b1;
            default:                        return 1'b0;
        endcase
    endfunction

endpackage

// ==== hw/storeAlign.sv ====
`timescale 1ns/1ns

module storeAlign import memAccessPkg::*; (
    input  memOp                    op,
    input  logic [1:0]              addrLow,
    input  logic [DATA_WIDTH-1:0]   storeData,
    output logic [BYTE_LANES-1:0]   byteWen,
    output logic [DATA_WIDTH-1:0]   wrData
);

    always_comb begin
        byteWen = '0;                                      // non-store ops write nothing
        wrData  = '0;
        case (op)
            SB: begin
                byteWen = 4'b0001 << addrLow;
                wrData  = {24'b0, storeData[7:0]} << {addrLow, 3'b000};
            end
            SH: begin
                if (addrLow[1]) begin
                    byteWen = 4'b1100;
                    wrData  = {storeData[15:0], 16'b0};
                end else begin
                    byteWen = 4'b0011;
                    wrData  = {16'b0, storeData[15:0]};
                end
            end
            SW: begin
                byteWen = 4'b1111;
                wrData  = storeData;
            end
            SWL: begin                                     // top source bytes into lanes addr..0
                case (addrLow)
                    2'd0:    byteWen = 4'b0001;
                    2'd1:    byteWen = 4'b0011;
                    2'd2:    byteWen = 4'b0111;
                    default: byteWen = 4'b1111;
                endcase
                wrData = storeData >> {~addrLow, 3'b000};
            end
            SWR: begin                                     // low source bytes into lanes addr..3
                case (addrLow)
                    2'd0:    byteWen = 4'b1111;
                    2'd1:    byteWen = 4'b1110;
                    2'd2:    byteWen = 4'b1100;
                    default: byteWen = 4'b1000;
                endcase
                wrData = storeData << {addrLow, 3'b000};
            end
            default: begin
                byteWen = '0;
                wrData  = '0;
            end
        endcase
    end

endmodule

// ==== hw/loadAlign.sv ====
`timescale 1ns/1ns

module loadAlign import memAccessPkg::*; (
    input  memOp                    op,
    input  logic [1:0]              addrLow,
    input  logic [DATA_WIDTH-1:0]   memWord,
    input  logic [DATA_WIDTH-1:0]   regOld,
    output logic [DATA_WIDTH-1:0]   loadResult
);

    logic [7:0]  laneByte;                                 // addressed byte
    logic [15:0] laneHalf;                                 // addressed halfword

    always_comb begin
        laneByte = memWord[{addrLow, 3'b000} +: 8];
        laneHalf = addrLow[1] ? memWord[31:16] : memWord[15:0];
    end

    always_comb begin
        case (op)
            LB: begin
                loadResult = {{24{laneByte[7]}}, laneByte};
            end
            LBU: begin
                loadResult = {24'b0, laneByte};
            end
            LH: begin
                loadResult = {{16{laneHalf[15]}}, laneHalf};
            end
            LHU: begin
                loadResult = {16'b0, laneHalf};
            end
            LW: begin
                loadResult = memWord;
            end
            LWL: begin
                // low memory lanes fill the top of the register
                case (addrLow)
                    2'd0:    loadResult = {memWord[7:0],  regOld[23:0]};
                    2'd1:    loadResult = {memWord[15:0], regOld[15:0]};
                    2'd2:    loadResult = {memWord[23:0], regOld[7:0]};
                    default: loadResult = memWord;
                endcase
            end
            LWR: begin
                // high memory lanes fill the bottom of the register
                case (addrLow)
                    2'd0:    loadResult = memWord;
                    2'd1:    loadResult = {regOld[31:24], memWord[31:8]};
                    2'd2:    loadResult = {regOld[31:16], memWord[31:16]};
                    default: loadResult = {regOld[31:8],  memWord[31:24]};
                endcase
            end
            default: begin
                loadResult = '0;                           // stores and NOP
            end
        endcase
    end

endmodule

// ==== hw/dataRam.sv ====
`timescale 1ns/1ns

module dataRam import memAccessPkg::*; (
    input  logic                        clk,
    input  logic [BYTE_LANES-1:0]       wen,
    input  logic [RAM_WORDS_LOG2-1:0]   addr,
    input  logic [DATA_WIDTH-1:0]       wrData,
    output logic [DATA_WIDTH-1:0]       rdData
);

    logic [DATA_WIDTH-1:0] mem [RAM_WORDS];

    always_ff @(posedge clk) begin
        for (int lane = 0; lane < BYTE_LANES; lane++) begin
            if (wen[lane]) begin
                mem[addr][lane*8 +: 8] <= wrData[lane*8 +: 8];   // per-lane write
            end
        end
        rdData <= mem[addr];                                     // old data on a write cycle
    end

endmodule

// ==== hw/accessSequencer.sv ====
`timescale 1ns/1ns

module accessSequencer import memAccessPkg::*; (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        reqValid,
    input  memOp                        reqOp,
    input  logic [ADDR_WIDTH-1:0]       reqAddr,
    input  logic [DATA_WIDTH-1:0]       reqStoreData,
    input  logic [DATA_WIDTH-1:0]       reqRegOld,
    input  logic [BYTE_LANES-1:0]       alignedWen,
    input  logic [DATA_WIDTH-1:0]       alignedWrData,
    output logic [BYTE_LANES-1:0]       ramWen,
    output logic [RAM_WORDS_LOG2-1:0]   ramAddr,
    output logic [DATA_WIDTH-1:0]       ramWrData,
    output memOp                        pendOp,
    output logic [1:0]                  pendAddrLow,
    output logic [DATA_WIDTH-1:0]       pendRegOld,
    input  logic [DATA_WIDTH-1:0]       loadResult,
    output logic                        respValid,
    output logic [DATA_WIDTH-1:0]       respLoadData,
    output logic                        respAddrError
);

    logic misaligned;

    always_comb begin
        case (reqOp)
            LH, LHU, SH: misaligned = reqAddr[0];          // halfword needs even address
            LW, SW:      misaligned = |reqAddr[1:0];
            default:     misaligned = 1'b0;                // byte and partial-word ops never fault
        endcase
    end

    assign ramAddr   = reqAddr[RAM_WORDS_LOG2+1:2];        // word index
    assign ramWen    = (!reset && reqValid && isStoreOp(reqOp) && !misaligned) ? alignedWen : '0;
    assign ramWrData = alignedWrData;

    always_ff @(posedge clk) begin
        if (reset) begin
            respValid     <= 1'b0;
            respAddrError <= 1'b0;
            pendOp        <= NOP;
        end else begin
            respValid     <= reqValid;
            respAddrError <= reqValid && misaligned;
            pendOp        <= reqValid ? reqOp : NOP;
        end
    end

    // payload for the load side, meaningful only with respValid
    always_ff @(posedge clk) begin
        pendAddrLow <= reqAddr[1:0];
        pendRegOld  <= reqRegOld;
    end

    assign respLoadData = (respValid && isLoadOp(pendOp) && !respAddrError) ? loadResult : '0;

endmodule

// ==== hw/memStage.sv ====
`timescale 1ns/1ns

module memStage import memAccessPkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    reqValid,
    input  memOp                    reqOp,
    input  logic [ADDR_WIDTH-1:0]   reqAddr,
    input  logic [DATA_WIDTH-1:0]   reqStoreData,
    input  logic [DATA_WIDTH-1:0]   reqRegOld,
    output logic                    respValid,
    output logic [DATA_WIDTH-1:0]   respLoadData,
    output logic                    respAddrError
);

    logic [BYTE_LANES-1:0]      alignedWen;
    logic [DATA_WIDTH-1:0]      alignedWrData;
    logic [BYTE_LANES-1:0]      ramWen;
    logic [RAM_WORDS_LOG2-1:0]  ramAddr;
    logic [DATA_WIDTH-1:0]      ramWrData;
    logic [DATA_WIDTH-1:0]      ramRdData;
    memOp                       pendOp;                    // op one cycle behind
    logic [1:0]                 pendAddrLow;
    logic [DATA_WIDTH-1:0]      pendRegOld;
    logic [DATA_WIDTH-1:0]      loadResult;

    storeAlign storeAlignInst (
        .op        (reqOp),
        .addrLow   (reqAddr[1:0]),
        .storeData (reqStoreData),
        .byteWen   (alignedWen),
        .wrData    (alignedWrData)
    );

    accessSequencer accessSequencerInst (
        .clk           (clk),
        .reset         (reset),
        .reqValid      (reqValid),
        .reqOp         (reqOp),
        .reqAddr       (reqAddr),
        .reqStoreData  (reqStoreData),
        .reqRegOld     (reqRegOld),
        .alignedWen    (alignedWen),
        .alignedWrData (alignedWrData),
        .ramWen        (ramWen),
        .ramAddr       (ramAddr),
        .ramWrData     (ramWrData),
        .pendOp        (pendOp),
        .pendAddrLow   (pendAddrLow),
        .pendRegOld    (pendRegOld),
        .loadResult    (loadResult),
        .respValid     (respValid),
        .respLoadData  (respLoadData),
        .respAddrError (respAddrError)
    );

    dataRam dataRamInst (
        .clk    (clk),
        .wen    (ramWen),
        .addr   (ramAddr),
        .wrData (ramWrData),
        .rdData (ramRdData)
    );

    loadAlign loadAlignInst (
        .op         (pendOp),
        .addrLow    (pendAddrLow),
        .memWord    (ramRdData),
        .regOld     (pendRegOld),
        .loadResult (loadResult)
    );

endmodule

// ==== tests/clockGen.sv ====
`timescale 1ns/1ns

module clockGen (
    output logic clk,
    output logic reset
);

    localparam int HALF_PERIOD  = 10;                      // 20 ns clock
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;                                                // release off the edge
        reset = 1'b0;
    end

endmodule

// ==== tests/memStage_asserts.sv ====
`timescale 1ns/1ns

module memStageAsserts import memAccessPkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    reqValid,
    input  memOp                    reqOp,
    input  logic [ADDR_WIDTH-1:0]   reqAddr,
    input  logic [BYTE_LANES-1:0]   ramWen,
    input  logic                    respValid,
    input  logic                    respAddrError
);

    int   failCount = 0;                                   // read by the testbench
    logic misalignedReq;

    assign misalignedReq = ((reqOp == LH || reqOp == LHU || reqOp == SH) && reqAddr[0])
                        || ((reqOp == LW || reqOp == SW) && reqAddr[1:0] != 2'b00);

    respFollowsReq: assert property (@(posedge clk)
        !$past(reset) |-> respValid == $past(reqValid))
        else begin
            failCount++;
            $error("respValid did not follow reqValid by exactly one cycle");
        end

    respQuietAfterReset: assert property (@(posedge clk)
        $past(reset) |-> !respValid && !respAddrError)
        else begin
            failCount++;
            $error("response active right after reset");
        end

    noWriteInReset: assert property (@(posedge clk) reset |-> ramWen == '0)
        else begin
            failCount++;
            $error("RAM write enable active during reset");
        end

    misalignedStoreNoWrite: assert property (@(posedge clk)
        reqValid && isStoreOp(reqOp) && misalignedReq |-> ramWen == '0)
        else begin
            failCount++;
            $error("misaligned store reached the RAM");
        end

    wordStoreAllLanes: assert property (@(posedge clk)
        !reset && reqValid && reqOp == SW && reqAddr[1:0] == 2'b00 |-> ramWen == 4'b1111)
        else begin
            failCount++;
            $error("aligned SW did not enable all four lanes");
        end

endmodule

bind memStage memStageAsserts assertsInst (
    .clk           (clk),
    .reset         (reset),
    .reqValid      (reqValid),
    .reqOp         (reqOp),
    .reqAddr       (reqAddr),
    .ramWen        (ramWen),
    .respValid     (respValid),
    .respAddrError (respAddrError)
);

// ==== tests/memStageTb.sv ====
`timescale 1ns/1ns

module memStageTb import memAccessPkg::*; ();

    localparam int RESET_CYCLES   = 10;
    localparam int SWLW_ITERS     = 20;
    localparam int SUBWORD_WORDS  = 4;
    localparam int PARTIAL_WORDS  = 2;
    localparam int MISALIGN_WORDS = 2;
    localparam int RANDOM_REQS    = 2000;
    localparam int TEST_CYCLES    = RESET_CYCLES + RAM_WORDS + SWLW_ITERS * 6 + SUBWORD_WORDS * 12
                                  + PARTIAL_WORDS * 24 + MISALIGN_WORDS * 15 + RANDOM_REQS + 7 * 3;
    localparam int MAX_CYCLES     = 2 * TEST_CYCLES;       // generous margin over the tests

    typedef struct packed {
        memOp        op;
        logic [9:0]  addr;
        logic [31:0] data;
        logic        err;
    } expResp;

    logic clk, reset, reqValid, respValid, respAddrError;
    memOp reqOp;
    logic [ADDR_WIDTH-1:0] reqAddr;
    logic [DATA_WIDTH-1:0] reqStoreData, reqRegOld, respLoadData;
    logic [7:0]  shadow [RAM_WORDS * 4];                   // byte-wide model of the RAM
    expResp      expQ [$];
    logic [31:0] lfsrState;
    int passCount = 0, errorCount = 0, passAtStart = 0, errorsAtStart = 0, cycleCount = 0;

    clockGen clockGenInst (.clk(clk), .reset(reset));

    memStage memStage_i (
        .clk(clk), .reset(reset), .reqValid(reqValid), .reqOp(reqOp), .reqAddr(reqAddr),
        .reqStoreData(reqStoreData), .reqRegOld(reqRegOld), .respValid(respValid),
        .respLoadData(respLoadData), .respAddrError(respAddrError)
    );

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];   // x^32+x^22+x^2+x+1
            lfsrState = {lfsrState[30:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic logic [31:0] fillWord(input logic [7:0] w);
        return {w, ~w, w ^ 8'h5A, w + 8'hC3};
    endfunction

    function automatic logic isMisaligned(input memOp op, input logic [9:0] a);
        return ((op == LH || op == LHU || op == SH) && a[0])
            || ((op == LW || op == SW) && a[1:0] != 0);
    endfunction

    function automatic logic [31:0] expectLoad(input memOp op, input logic [9:0] a,
                                               input logic [31:0] ro);
        logic [31:0] w, r;
        int base, off, hb;
        base = int'({a[9:2], 2'b00});
        off  = int'(a[1:0]);
        hb   = int'({a[9:1], 1'b0});
        w    = {shadow[base + 3], shadow[base + 2], shadow[base + 1], shadow[base]};
        r    = ro;                                         // partial loads keep the rest
        case (op)
            LB:      r = {{24{shadow[a][7]}}, shadow[a]};
            LBU:     r = {24'b0, shadow[a]};
            LH:      r = {{16{shadow[hb + 1][7]}}, shadow[hb + 1], shadow[hb]};
            LHU:     r = {16'b0, shadow[hb + 1], shadow[hb]};
            LW:      r = w;
            LWL:     for (int k = 0; k <= off; k++) r[(3 - off + k) * 8 +: 8] = w[k * 8 +: 8];
            LWR:     for (int k = off; k < 4; k++) r[(k - off) * 8 +: 8] = w[k * 8 +: 8];
            default: r = '0;                               // stores answer with zero
        endcase
        return r;
    endfunction

    function automatic void applyStore(input memOp op, input logic [9:0] a, input logic [31:0] sd);
        int base, off, hb;
        base = int'({a[9:2], 2'b00});
        off  = int'(a[1:0]);
        hb   = int'({a[9:1], 1'b0});
        case (op)
            SB:      shadow[a] = sd[7:0];
            SH:      for (int k = 0; k < 2; k++) shadow[hb + k] = sd[k * 8 +: 8];
            SW:      for (int k = 0; k < 4; k++) shadow[base + k] = sd[k * 8 +: 8];
            SWL:     for (int k = 0; k <= off; k++) shadow[base + k] = sd[(3 - off + k) * 8 +: 8];
            SWR:     for (int k = off; k < 4; k++) shadow[base + k] = sd[(k - off) * 8 +: 8];
            default: ;
        endcase
    endfunction

    task automatic issue(input memOp op, input logic [9:0] a, input logic [31:0] sd,
                         input logic [31:0] ro);
        expResp e;
        e.op   = op;
        e.addr = a;
        e.err  = isMisaligned(op, a);
        e.data = e.err ? '0 : expectLoad(op, a, ro);
        if (!e.err) applyStore(op, a, sd);                 // faulting stores leave memory alone
        reqValid     = 1'b1;
        reqOp        = op;
        reqAddr      = {22'b0, a};
        reqStoreData = sd;
        reqRegOld    = ro;
        @(posedge clk);
        expQ.push_back(e);                                 // response due at the next negedge
        #2;
    endtask

    task automatic finishTest(input string name);
        reqValid = 1'b0;
        reqOp    = NOP;
        while (expQ.size() != 0) begin
            @(negedge clk);
        end
        $display("test %-10s finished: %0d passed, %0d failed", name,
                 passCount - passAtStart, errorCount - errorsAtStart);
        passAtStart   = passCount;
        errorsAtStart = errorCount;
        @(posedge clk);
        #2;
    endtask

    // outputs are settled mid-cycle
    always @(negedge clk) begin : respMonitor
        expResp e;
        if (respValid && expQ.size() == 0) begin
            errorCount++;
            $display("Response at time %0t arrived with no request outstanding", $time);
        end else if (respValid) begin
            e = expQ.pop_front();
            assert (respLoadData == e.data && respAddrError == e.err) passCount++;
            else begin
                errorCount++;
                $display("Error at %0t: %s addr %h expected data %h err %b, got data %h err %b",
                         $time, e.op.name(), e.addr, e.data, e.err, respLoadData, respAddrError);
            end
        end else if (expQ.size() != 0) begin
            errorCount++;
            void'(expQ.pop_front());
            $display("Response missing at time %0t for an accepted request", $time);
        end
    end

    initial begin : watchdog
        while (cycleCount < MAX_CYCLES) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        logic [9:0] base;
        int totalFails;
        reqValid     = 1'b0;
        reqOp        = NOP;
        reqAddr      = '0;
        reqStoreData = '0;
        reqRegOld    = '0;
        lfsrState    = 32'd84189;
        repeat (2) @(posedge clk);
        #2;
        reqValid     = 1'b1;                               // aligned store held inside reset
        reqOp        = SW;
        reqStoreData = 32'hFFFF_FFFF;
        @(negedge reset);
        reqValid     = 1'b0;
        reqOp        = NOP;
        reqStoreData = '0;
        @(posedge clk);
        #2;
        for (int w = 0; w < RAM_WORDS; w++) begin
            issue(SW, 10'(w * 4), fillWord(8'(w)), '0);
        end
        finishTest("fill");
        for (int i = 0; i < SWLW_ITERS; i++) begin
            base = {8'(randBits(8)), 2'b00};
            issue(SW, base, randBits(32), '0);
            issue(LW, base, '0, '0);
            issue(LB, base + 10'(randBits(2)), '0, '0);
            issue(LBU, base + 10'(randBits(2)), '0, '0);
            issue(LH, base + {8'b0, 1'(randBits(1)), 1'b0}, '0, '0);
            issue(LHU, base + {8'b0, 1'(randBits(1)), 1'b0}, '0, '0);
        end
        finishTest("swLw");
        for (int w = 0; w < SUBWORD_WORDS; w++) begin
            base = {8'(randBits(8)), 2'b00};
            for (int off = 0; off < 4; off++) begin
                issue(SB, base + 10'(off), randBits(32), '0);
                issue(LW, base, '0, '0);
            end
            for (int off = 0; off < 4; off += 2) begin
                issue(SH, base + 10'(off), randBits(32), '0);
                issue(LW, base, '0, '0);
            end
        end
        finishTest("subword");
        for (int w = 0; w < PARTIAL_WORDS; w++) begin
            base = {8'(randBits(8)), 2'b00};
            for (int off = 0; off < 4; off++) begin
                issue(SWL, base + 10'(off), randBits(32), '0);
                issue(LW, base, '0, '0);
                issue(SWR, base + 10'(off), randBits(32), '0);
                issue(LW, base, '0, '0);
                issue(LWL, base + 10'(off), '0, randBits(32));
                issue(LWR, base + 10'(off), '0, randBits(32));
            end
        end
        finishTest("partial");
        for (int w = 0; w < MISALIGN_WORDS; w++) begin
            base = {8'(randBits(8)), 2'b00};
            for (int off = 1; off < 4; off++) begin
                if (off % 2 == 1) begin
                    issue(LH, base + 10'(off), '0, '0);
                    issue(LHU, base + 10'(off), '0, '0);
                    issue(SH, base + 10'(off), randBits(32), '0);
                end
                issue(LW, base + 10'(off), '0, '0);
                issue(SW, base + 10'(off), randBits(32), '0);
                issue(LW, base, '0, '0);                   // memory must be untouched
            end
        end
        finishTest("misalign");
        for (int i = 0; i < RANDOM_REQS; i++) begin
            issue(memOp'(4'(randBits(4) % 12 + 1)), 10'(randBits(10)), randBits(32), randBits(32));
        end
        finishTest("random");
        totalFails = errorCount + memStage_i.assertsInst.failCount;
        $display("checks passed %0d, checks failed %0d, assertion failures %0d",
                 passCount, errorCount, memStage_i.assertsInst.failCount);
        if (totalFails == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
hw/memAccessPkg.sv
hw/storeAlign.sv
hw/loadAlign.sv
hw/dataRam.sv
hw/accessSequencer.sv
hw/memStage.sv
tests/clockGen.sv
tests/memStage_asserts.sv
tests/memStageTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= memStageTb
BUILD_DIR ?= obj_dir
FILELIST  ?= verilog.f
VFLAGS    ?= --binary --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= Simulation completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
